// File: include/calc_defs.svh
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// operand and result word
`define CALC_WIDTH 32

// low bits of each operand fed to the magnitude unit
// two squares of this width sum into 31 bits
`define CALC_COMP_WIDTH 15

// cycles between ticks unless overridden at the top
`define CALC_SAMPLE_PERIOD 10000

// one quotient bit per iteration
`define CALC_DIV_STEPS 32

// two radicand bits per iteration
`define CALC_ROOT_STEPS 16

`endif

// File: rtl/calc_data_pkg.sv
`default_nettype none

`include "calc_defs.svh"

package calc_data_pkg;

  // full operand or result word
  typedef logic [`CALC_WIDTH-1:0] word_t;

  // magnitude input component
  typedef logic [`CALC_COMP_WIDTH-1:0] comp_t;

  // floor root of a word, half its width
  typedef logic [`CALC_WIDTH/2-1:0] root_t;

  // iteration index for divider and root unit
  // wide enough for 32 divider steps
  typedef logic [5:0] step_t;

endpackage

`default_nettype wire

// File: rtl/calc_ctrl_pkg.sv
`default_nettype none

package calc_ctrl_pkg;

  // sequencer FSM states
  typedef enum logic [1:0] {
    idle   = 2'd0,
    run    = 2'd1,
    finish = 2'd2
  } seq_state_e;

  // which result pair drives the outputs
  typedef enum logic {
    view_div = 1'b0,
    view_mag = 1'b1
  } view_e;

endpackage

`default_nettype wire

// File: rtl/sample_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module sample_timer #(
  parameter int sample_period = `CALC_SAMPLE_PERIOD
) (
  input  wire  clk_100mhz,
  input  wire  reset,
  output logic tick
);

  localparam int cnt_width = $clog2(sample_period);
  localparam logic [cnt_width-1:0] last_count = cnt_width'(sample_period - 1);

  logic [cnt_width-1:0] count;

  // free-running count with wrap at the end of each period
  // tick is registered so it lands one cycle after the last count
  always_ff @(posedge clk_100mhz) begin
    if (reset) begin
      count <= '0;
      tick  <= 1'b0;
    end else begin
      if (count == last_count) begin
        count <= '0;
        tick  <= 1'b1;
      end else begin
        count <= count + 1'b1;
        tick  <= 1'b0;
      end
    end
  end

  // period of at least two keeps ticks apart
  tick_single_cycle: assert property (
    @(posedge clk_100mhz) disable iff (reset)
    tick |=> !tick
  ) else $error("sample_timer: tick held for more than one cycle");

endmodule

`default_nettype wire

// File: rtl/seq_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module seq_divider (
  input  wire                        clk_100mhz,
  input  wire                        reset,
  input  wire                        start,
  input  wire  calc_data_pkg::word_t dividend,
  input  wire  calc_data_pkg::word_t divisor,
  output logic                       done,
  output calc_data_pkg::word_t       quotient,
  output calc_data_pkg::word_t       remainder
);

  import calc_data_pkg::*;

  localparam step_t last_step = step_t'(`CALC_DIV_STEPS - 1);

  logic  busy;
  step_t step;
  word_t divisor_r;

  // partial remainder with the next dividend bit shifted in
  logic [`CALC_WIDTH:0] trial;
  logic [`CALC_WIDTH:0] diff;
  logic                 fits;

  always_comb begin
    trial = {remainder, quotient[`CALC_WIDTH-1]};
    diff  = trial - {1'b0, divisor_r};
    // zero divisor always fits
    // gives all ones and the dividend back as remainder
    fits  = (trial >= {1'b0, divisor_r});
  end

  // step counter and done pulse
  always_ff @(posedge clk_100mhz) begin
    if (reset) begin
      busy <= 1'b0;
      step <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // quotient register doubles as the dividend shifter
  // bits of the dividend leave at the top as quotient bits enter below
  always_ff @(posedge clk_100mhz) begin
    if (start) begin
      quotient  <= dividend;
      remainder <= '0;
      divisor_r <= divisor;
    end else if (busy) begin
      if (fits)
        remainder <= diff[`CALC_WIDTH-1:0];
      else
        remainder <= trial[`CALC_WIDTH-1:0];
      quotient <= {quotient[`CALC_WIDTH-2:0], fits};
    end
  end

  // the sequencer only starts from idle
  no_start_while_busy: assert property (
    @(posedge clk_100mhz) disable iff (reset)
    start |-> !busy
  ) else $error("seq_divider: start received while a division was running");

endmodule

`default_nettype wire

// File: rtl/mag_root.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module mag_root (
  input  wire                        clk_100mhz,
  input  wire                        reset,
  input  wire                        start,
  input  wire  calc_data_pkg::word_t op_a,
  input  wire  calc_data_pkg::word_t op_b,
  output logic                       done,
  output calc_data_pkg::root_t       root,
  output calc_data_pkg::word_t       sum_sq
);

  import calc_data_pkg::*;

  localparam step_t last_step = step_t'(`CALC_ROOT_STEPS - 1);
  // signed remainder needs sign bit and shift headroom over the root
  localparam int rem_width = $bits(root_t) + 8;
  localparam int pad_width = rem_width - $bits(root_t) - 2;

  comp_t a_c;
  comp_t b_c;
  word_t sq_sum;

  logic  square_pending;
  logic  busy;
  step_t step;

  // radicand shifted out two bits per step from the top
  word_t                rad;
  logic [rem_width-1:0] rem_r;
  logic [rem_width-1:0] rem_shift;
  logic [rem_width-1:0] root_term;
  logic [rem_width-1:0] rem_next;

  // 15-bit squares sum into 31 bits
  always_comb begin
    sq_sum = word_t'(a_c) * word_t'(a_c) + word_t'(b_c) * word_t'(b_c);
  end

  // non-restoring digit step
  // subtract 4q+1 on a positive remainder, add 4q+3 on a negative one
  always_comb begin
    rem_shift = {rem_r[rem_width-3:0], rad[`CALC_WIDTH-1 -: 2]};
    if (rem_r[rem_width-1]) begin
      root_term = {{pad_width{1'b0}}, root, 2'b11};
      rem_next  = rem_shift + root_term;
    end else begin
      root_term = {{pad_width{1'b0}}, root, 2'b01};
      rem_next  = rem_shift - root_term;
    end
  end

  // one square cycle, then the root steps, then done
  always_ff @(posedge clk_100mhz) begin
    if (reset) begin
      square_pending <= 1'b0;
      busy           <= 1'b0;
      step           <= '0;
      done           <= 1'b0;
    end else begin
      done           <= 1'b0;
      square_pending <= start;
      if (square_pending) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (start) begin
      a_c <= op_a[`CALC_COMP_WIDTH-1:0];
      b_c <= op_b[`CALC_COMP_WIDTH-1:0];
    end
    if (square_pending) begin
      sum_sq <= sq_sum;
      rad    <= sq_sum;
      rem_r  <= '0;
      root   <= '0;
    end else if (busy) begin
      rad   <= {rad[`CALC_WIDTH-3:0], 2'b00};
      rem_r <= rem_next;
      // non-negative remainder means the new root bit is one
      root  <= {root[$bits(root_t)-2:0], ~rem_next[rem_width-1]};
    end
  end

  // floor property of the finished root
  root_not_too_large: assert property (
    @(posedge clk_100mhz) disable iff (reset)
    done |-> (word_t'(root) * word_t'(root)) <= sum_sq
  ) else $error("mag_root: root squared exceeds the sum of squares");

endmodule

`default_nettype wire

// File: rtl/calc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module calc_sequencer (
  input  wire                          clk_100mhz,
  input  wire                          reset,
  input  wire                          tick,
  input  wire  calc_data_pkg::word_t   dividend,
  input  wire  calc_data_pkg::word_t   divisor,
  output logic                         start,
  output calc_data_pkg::word_t         op_a,
  output calc_data_pkg::word_t         op_b,
  input  wire                          div_done,
  input  wire  calc_data_pkg::word_t   quotient,
  input  wire  calc_data_pkg::word_t   remainder,
  input  wire                          root_done,
  input  wire  calc_data_pkg::root_t   root,
  input  wire  calc_data_pkg::word_t   sum_sq,
  output calc_data_pkg::word_t         quotient_q,
  output calc_data_pkg::word_t         remainder_q,
  output calc_data_pkg::root_t         root_q,
  output calc_data_pkg::word_t         sum_sq_q,
  output logic                         div_by_zero_q,
  output logic                         result_valid
);

  import calc_data_pkg::*;
  import calc_ctrl_pkg::*;

  seq_state_e state;

  // sticky per-unit completion flags
  logic div_seen;
  logic root_seen;
  logic both_done;

  // per-unit results captured on their own done pulses
  word_t quotient_hold;
  word_t remainder_hold;
  root_t root_hold;
  word_t sum_sq_hold;

  // a done pulse counts in the same cycle it arrives
  assign both_done = (div_seen | div_done) & (root_seen | root_done);

  always_ff @(posedge clk_100mhz) begin
    if (reset) begin
      state        <= idle;
      start        <= 1'b0;
      div_seen     <= 1'b0;
      root_seen    <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      start        <= 1'b0;
      result_valid <= 1'b0;
      case (state)
        idle: begin
          if (tick) begin
            state     <= run;
            start     <= 1'b1;
            div_seen  <= 1'b0;
            root_seen <= 1'b0;
          end
        end
        run: begin
          if (div_done)
            div_seen <= 1'b1;
          if (root_done)
            root_seen <= 1'b1;
          // strobe goes out one cycle after the later done
          if (both_done) begin
            state        <= finish;
            result_valid <= 1'b1;
          end
        end
        finish: begin
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // operands handed to both units with the start pulse
  always_ff @(posedge clk_100mhz) begin
    if (state == idle && tick) begin
      op_a <= dividend;
      op_b <= divisor;
    end
  end

  // capture each unit as it finishes
  always_ff @(posedge clk_100mhz) begin
    if (div_done) begin
      quotient_hold  <= quotient;
      remainder_hold <= remainder;
    end
    if (root_done) begin
      root_hold   <= root;
      sum_sq_hold <= sum_sq;
    end
  end

  // visible results move together with result_valid
  // the later unit is taken straight from its ports
  always_ff @(posedge clk_100mhz) begin
    if (reset) begin
      quotient_q    <= '0;
      remainder_q   <= '0;
      root_q        <= '0;
      sum_sq_q      <= '0;
      div_by_zero_q <= 1'b0;
    end else if (state == run && both_done) begin
      quotient_q    <= div_done ? quotient : quotient_hold;
      remainder_q   <= div_done ? remainder : remainder_hold;
      root_q        <= root_done ? root : root_hold;
      sum_sq_q      <= root_done ? sum_sq : sum_sq_hold;
      div_by_zero_q <= (op_b == '0);
    end
  end

  result_valid_pulse: assert property (
    @(posedge clk_100mhz) disable iff (reset)
    result_valid |=> !result_valid
  ) else $error("calc_sequencer: result_valid longer than one cycle");

  // sample period shorter than the unit latency
  tick_only_when_idle: assert property (
    @(posedge clk_100mhz) disable iff (reset)
    tick |-> state == idle
  ) else $error("calc_sequencer: tick arrived while a calculation was running");

endmodule

`default_nettype wire

// File: rtl/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module calc_top #(
  parameter int sample_period = `CALC_SAMPLE_PERIOD
) (
  input  wire                         clk_100mhz,
  input  wire                         reset,
  input  wire  calc_data_pkg::word_t  dividend,
  input  wire  calc_data_pkg::word_t  divisor,
  input  wire  calc_ctrl_pkg::view_e  view_sel,
  output calc_data_pkg::word_t        result_a,
  output calc_data_pkg::word_t        result_b,
  output logic                        div_by_zero,
  output logic                        result_valid
);

  import calc_data_pkg::*;
  import calc_ctrl_pkg::*;

  logic  tick;
  logic  start;
  word_t op_a;
  word_t op_b;

  // raw unit outputs
  logic  div_done;
  word_t quotient;
  word_t remainder;
  logic  root_done;
  root_t root;
  word_t sum_sq;

  // results latched at the strobe
  word_t quotient_q;
  word_t remainder_q;
  root_t root_q;
  word_t sum_sq_q;

  sample_timer #(
    .sample_period(sample_period)
  ) u_timer (
    .clk_100mhz(clk_100mhz),
    .reset     (reset),
    .tick      (tick)
  );

  calc_sequencer u_seq (
    .clk_100mhz   (clk_100mhz),
    .reset        (reset),
    .tick         (tick),
    .dividend     (dividend),
    .divisor      (divisor),
    .start        (start),
    .op_a         (op_a),
    .op_b         (op_b),
    .div_done     (div_done),
    .quotient     (quotient),
    .remainder    (remainder),
    .root_done    (root_done),
    .root         (root),
    .sum_sq       (sum_sq),
    .quotient_q   (quotient_q),
    .remainder_q  (remainder_q),
    .root_q       (root_q),
    .sum_sq_q     (sum_sq_q),
    .div_by_zero_q(div_by_zero),
    .result_valid (result_valid)
  );

  seq_divider u_div (
    .clk_100mhz(clk_100mhz),
    .reset     (reset),
    .start     (start),
    .dividend  (op_a),
    .divisor   (op_b),
    .done      (div_done),
    .quotient  (quotient),
    .remainder (remainder)
  );

  mag_root u_mag (
    .clk_100mhz(clk_100mhz),
    .reset     (reset),
    .start     (start),
    .op_a      (op_a),
    .op_b      (op_b),
    .done      (root_done),
    .root      (root),
    .sum_sq    (sum_sq)
  );

  // view mux over the latched pairs
  // switching views needs no new tick
  always_comb begin
    case (view_sel)
      view_mag: begin
        result_a = word_t'(root_q);
        result_b = sum_sq_q;
      end
      default: begin
        result_a = quotient_q;
        result_b = remainder_q;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: test/calc_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module calc_top_tb;

  import calc_data_pkg::*;
  import calc_ctrl_pkg::*;

  localparam int period = 100;
  // result strobe comes 35 cycles after each tick
  localparam int wait_limit = 500;

  // all four expected results plus the zero-divisor flag
  typedef struct packed {
    word_t quo;
    word_t rem;
    word_t rt;
    word_t ssq;
    logic  dbz;
  } expect_t;

  logic  clk_100mhz;
  logic  reset;
  word_t dividend;
  word_t divisor;
  view_e view_sel;
  word_t result_a;
  word_t result_b;
  logic  div_by_zero;
  logic  result_valid;

  // operands the DUT captured for the pending result
  word_t cur_dividend;
  word_t cur_divisor;
  word_t rng_state;
  word_t shift_v;
  word_t divisor_v;
  int    cycle_count;
  int    last_strobe_cycle;
  int    strobe_count;
  int    start_cycle;
  int    start_strobes;

  calc_top #(
    .sample_period(period)
  ) UUT (
    .clk_100mhz  (clk_100mhz),
    .reset       (reset),
    .dividend    (dividend),
    .divisor     (divisor),
    .view_sel    (view_sel),
    .result_a    (result_a),
    .result_b    (result_b),
    .div_by_zero (div_by_zero),
    .result_valid(result_valid)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  always @(posedge clk_100mhz) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic word_t lcg_next(input word_t state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t random_word();
    rng_state = lcg_next(rng_state);
    return rng_state;
  endfunction

  // expected values straight from the arithmetic rules
  function automatic expect_t expected_results(input word_t a, input word_t b);
    expect_t     e;
    logic [63:0] ca;
    logic [63:0] cb;
    logic [63:0] trial;
    word_t       r;
    // zero divisor gives all ones and the dividend back
    if (b == '0) begin
      e.quo = '1;
      e.rem = a;
    end else begin
      e.quo = a / b;
      e.rem = a % b;
    end
    e.dbz = (b == '0);
    ca = 64'(a[`CALC_COMP_WIDTH-1:0]);
    cb = 64'(b[`CALC_COMP_WIDTH-1:0]);
    e.ssq = word_t'(ca * ca + cb * cb);
    // greedy bit search for the largest root whose square fits
    r = '0;
    for (int i = 15; i >= 0; i--) begin
      trial = 64'(r | (word_t'(1) << i));
      if (trial * trial <= 64'(e.ssq))
        r = word_t'(trial);
    end
    e.rt = r;
    return e;
  endfunction

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  // compare whichever pair the current view shows
  task automatic check_outputs(input expect_t e);
    if (view_sel == view_mag) begin
      check_word("root", result_a, e.rt);
      check_word("sum of squares", result_b, e.ssq);
    end else begin
      check_word("quotient", result_a, e.quo);
      check_word("remainder", result_b, e.rem);
    end
    check_flag("div_by_zero", div_by_zero, e.dbz);
  endtask

  // new operands just after a rising edge
  task automatic drive_inputs(input word_t a, input word_t b, input view_e v);
    @(posedge clk_100mhz);
    #1;
    dividend     = a;
    divisor      = b;
    view_sel     = v;
    cur_dividend = a;
    cur_divisor  = b;
  endtask

  task automatic wait_result();
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < wait_limit && !seen; i++) begin
      @(negedge clk_100mhz);
      seen = result_valid;
    end
    // strobe bookkeeping settles before the caller reads it
    #1;
    if (!seen) begin
      $display("timeout: result_valid did not arrive within %0d cycles", wait_limit);
      stop_on_failure();
    end
  endtask

  // compare on every strobe, sampled mid-cycle where outputs are settled
  always @(negedge clk_100mhz) begin
    if (!reset && result_valid) begin
      // one strobe per sample period, nothing in between
      if (strobe_count > 0)
        check_word("strobe interval", word_t'(cycle_count - last_strobe_cycle),
                   word_t'(period));
      last_strobe_cycle = cycle_count;
      strobe_count = strobe_count + 1;
      check_outputs(expected_results(cur_dividend, cur_divisor));
    end
  end

  initial begin
    rng_state     = 32'hbfe0cdcf;
    cycle_count   = 0;
    strobe_count  = 0;
    reset         = 1'b1;
    dividend      = 32'd100;
    divisor       = 32'd7;
    view_sel      = view_div;
    cur_dividend  = 32'd100;
    cur_divisor   = 32'd7;
    repeat (16) @(posedge clk_100mhz);
    #1;
    reset = 1'b0;

    // quiet outputs after reset in both views
    @(negedge clk_100mhz);
    check_flag("result_valid after reset", result_valid, 1'b0);
    check_flag("div_by_zero after reset", div_by_zero, 1'b0);
    check_word("result_a after reset", result_a, '0);
    check_word("result_b after reset", result_b, '0);
    @(posedge clk_100mhz);
    #1;
    view_sel = view_mag;
    @(negedge clk_100mhz);
    check_word("result_a after reset", result_a, '0);
    check_word("result_b after reset", result_b, '0);
    @(posedge clk_100mhz);
    #1;
    view_sel = view_div;
    wait_result();

    // random division, divisor scaled down for varied quotients
    for (int n = 0; n < 200; n++) begin
      shift_v   = random_word();
      divisor_v = random_word() >> shift_v[31:27];
      if (divisor_v == '0)
        divisor_v = 32'd1;
      drive_inputs(random_word(), divisor_v, view_div);
      wait_result();
    end

    // divide by zero, then a nonzero divisor clears the flag
    drive_inputs(random_word(), 32'd0, view_div);
    wait_result();
    drive_inputs(32'd0, 32'd0, view_div);
    wait_result();
    drive_inputs(random_word(), 32'd5, view_div);
    wait_result();

    // magnitude edge pairs
    drive_inputs(32'd0, 32'd0, view_mag);
    wait_result();
    drive_inputs(32'h7fff, 32'h7fff, view_mag);
    wait_result();
    drive_inputs(32'd3, 32'd4, view_mag);
    wait_result();
    drive_inputs(32'd12, 32'd5, view_mag);
    wait_result();
    drive_inputs(32'h7fff, 32'd0, view_mag);
    wait_result();
    // upper bits must be ignored
    drive_inputs(32'hffff_8000, 32'h0001_8001, view_mag);
    wait_result();
    for (int n = 0; n < 40; n++) begin
      drive_inputs(random_word(), random_word(), view_mag);
      wait_result();
    end

    // flip views between strobes, latched pairs only
    start_strobes = strobe_count;
    for (int n = 0; n < 4; n++) begin
      @(posedge clk_100mhz);
      #1;
      view_sel = view_div;
      @(negedge clk_100mhz);
      check_outputs(expected_results(cur_dividend, cur_divisor));
      check_flag("result_valid during view switch", result_valid, 1'b0);
      @(posedge clk_100mhz);
      #1;
      view_sel = view_mag;
      @(negedge clk_100mhz);
      check_outputs(expected_results(cur_dividend, cur_divisor));
      check_flag("result_valid during view switch", result_valid, 1'b0);
    end
    check_word("strobes during view switch", word_t'(strobe_count - start_strobes), '0);

    // ten periods of steady strobes
    drive_inputs(random_word(), random_word(), view_div);
    wait_result();
    start_cycle   = cycle_count;
    start_strobes = strobe_count;
    for (int n = 0; n < 10; n++)
      wait_result();
    check_word("cycles over ten periods", word_t'(cycle_count - start_cycle),
               word_t'(10 * period));
    check_word("strobes over ten periods", word_t'(strobe_count - start_strobes),
               word_t'(10));

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: calc_top.f
+incdir+include
rtl/calc_data_pkg.sv
rtl/calc_ctrl_pkg.sv
rtl/sample_timer.sv
rtl/seq_divider.sv
rtl/mag_root.sv
rtl/calc_sequencer.sv
rtl/calc_top.sv
test/calc_top_tb.sv
